// ==== hw/gpu_dispatch_pkg.sv ====
`default_nettype none

package gpu_dispatch_pkg;

	// Task word layout
	localparam int TASK_W    = 29;
	localparam int VALID_BIT = 28;
	localparam int SW_ID_LSB = 20;
	localparam int SW_ID_W   = 8;
	localparam int PC_LSB    = 11;
	localparam int PC_W      = 9;
	localparam int MASK_LSB  = 3;
	localparam int MASK_W    = 8;
	localparam int NREG_LSB  = 0;
	localparam int NREG_W    = 3;

	// Sizes
	localparam int TASK_DEPTH = 256;
	localparam int TASK_AW    = 8;
	localparam int NUM_WARPS  = 8;
	localparam int WARP_W     = 3;
	localparam int NUM_REGS   = 32;
	localparam int NUM_PAIRS  = NUM_REGS / 2;
	localparam int PAIR_W     = 4;
	localparam int REG_CNT_W  = 6;
	localparam int REG_BASE_W = 5;
	// Active count runs 0 to NUM_WARPS
	localparam int ACT_W      = 4;
	localparam int DATA_W     = 32;

	// Host register map
	localparam int REG_ADDR_W = 2;
	localparam logic [REG_ADDR_W-1:0] ADDR_TASK   = 2'd0;
	localparam logic [REG_ADDR_W-1:0] ADDR_CTRL   = 2'd1;
	localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 2'd2;

	// Command bits in the control register
	typedef enum int unsigned {
		CTRL_START_BIT = 0,
		CTRL_CLEAR_BIT = 1
	} ctrl_bit_e;

	typedef enum logic [1:0] {
		WAITING  = 2'd0,
		WORKING  = 2'd1,
		COMPLETE = 2'd2,
		CLEARING = 2'd3
	} tm_state_e;

	// Registers are handed out in pairs, so the need is twice the code
	function automatic logic [REG_CNT_W-1:0] task_regs(input logic [TASK_W-1:0] word);
		return {2'b00, word[NREG_LSB +: NREG_W], 1'b0};
	endfunction

	// Word aligned start address
	function automatic logic [DATA_W-1:0] task_pc(input logic [TASK_W-1:0] word);
		return {21'd0, word[PC_LSB +: PC_W], 2'b00};
	endfunction

endpackage

`default_nettype wire

// ==== hw/task_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module task_queue import gpu_dispatch_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               q_push,
	input  logic [TASK_W-1:0]  task_word,
	input  logic               q_pop,
	input  logic               q_invalidate,
	input  logic [TASK_AW-1:0] exit_slot,
	input  logic               q_reset,
	output logic [TASK_W-1:0]  head_word,
	output logic [TASK_AW-1:0] head_slot,
	output logic               q_empty,
	output logic [TASK_W-1:0]  exit_word
);

	// Payload without the valid bit, valid bits kept apart
	logic [TASK_W-2:0]     mem [TASK_DEPTH];
	logic [TASK_DEPTH-1:0] valid;
	// Extra top bit tells full from empty
	logic [TASK_AW:0]      rd_ptr;
	logic [TASK_AW:0]      wr_ptr;
	logic                  q_full;
	logic                  do_push;

	assign q_empty = (rd_ptr == wr_ptr);
	assign q_full  = (rd_ptr[TASK_AW-1:0] == wr_ptr[TASK_AW-1:0]) &&
		(rd_ptr[TASK_AW] != wr_ptr[TASK_AW]);
	// Pushes into a full queue are dropped
	assign do_push = q_push && !q_full;

	assign head_slot = rd_ptr[TASK_AW-1:0];
	assign head_word = {valid[head_slot], mem[head_slot]};
	// Lookup of the task an exiting warp ran
	assign exit_word = {valid[exit_slot], mem[exit_slot]};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			valid  <= '0;
		end else if (q_reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			valid  <= '0;
		end else begin
			// Retire first so a push to the same slot wins
			if (q_invalidate) begin
				valid[exit_slot] <= 1'b0;
			end
			if (do_push) begin
				valid[wr_ptr[TASK_AW-1:0]] <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (q_pop && !q_empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Task payload storage
	always_ff @(posedge clk) begin
		if (do_push && !q_reset) begin
			mem[wr_ptr[TASK_AW-1:0]] <= task_word[TASK_W-2:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/warp_pool.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_pool import gpu_dispatch_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               wp_take,
	input  logic [TASK_AW-1:0] head_slot,
	input  logic               wp_return,
	input  logic [WARP_W-1:0]  exit_warp,
	input  logic               wp_reset,
	output logic [WARP_W-1:0]  free_warp,
	output logic               free_empty,
	output logic [TASK_AW-1:0] exit_slot
);

	// Free hardware warp ids, FIFO order
	logic [WARP_W-1:0]  free_list [NUM_WARPS];
	logic [WARP_W:0]    rd_ptr;
	logic [WARP_W:0]    wr_ptr;
	// Task slot each hardware warp is running
	logic [TASK_AW-1:0] slot_map [NUM_WARPS];

	assign free_warp  = free_list[rd_ptr[WARP_W-1:0]];
	assign free_empty = (rd_ptr == wr_ptr);
	assign exit_slot  = slot_map[exit_warp];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
			// Full from the start
			wr_ptr <= (WARP_W + 1)'(NUM_WARPS);
			for (int i = 0; i < NUM_WARPS; i++) begin
				free_list[i] <= WARP_W'(i);
			end
		end else if (wp_reset) begin
			rd_ptr <= '0;
			wr_ptr <= (WARP_W + 1)'(NUM_WARPS);
			for (int i = 0; i < NUM_WARPS; i++) begin
				free_list[i] <= WARP_W'(i);
			end
		end else begin
			if (wp_take && !free_empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Exited warp goes to the back of the list
			if (wp_return) begin
				free_list[wr_ptr[WARP_W-1:0]] <= exit_warp;
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wp_take && !free_empty) begin
			slot_map[free_warp] <= head_slot;
		end
	end

endmodule

`default_nettype wire

// ==== hw/reg_alloc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_alloc_unit import gpu_dispatch_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  alloc_req,
	input  logic [WARP_W-1:0]     alloc_warp,
	input  logic [NREG_W-1:0]     alloc_pairs,
	input  logic                  release_req,
	input  logic [WARP_W-1:0]     release_warp,
	output logic                  alloc_ready,
	output logic [REG_BASE_W-1:0] reg_base
);

	// One bit per register pair, set when taken
	logic [NUM_PAIRS-1:0] occupancy;
	logic [PAIR_W-1:0]    warp_base [NUM_WARPS];
	logic [NREG_W-1:0]    warp_size [NUM_WARPS];
	logic                 busy;
	logic                 fit_found;
	logic [PAIR_W-1:0]    fit_base;
	logic                 grant;
	logic [NUM_PAIRS-1:0] grant_mask;
	logic [NUM_PAIRS-1:0] rel_mask;

	// Run of cnt pairs starting at base
	function automatic logic [NUM_PAIRS-1:0] pair_mask(input logic [PAIR_W-1:0] base,
			input logic [NREG_W-1:0] cnt);
		logic [2*NUM_PAIRS-1:0] run;
		run = ((2*NUM_PAIRS)'(1) << cnt) - 1'b1;
		run = run << base;
		return run[NUM_PAIRS-1:0];
	endfunction

	// First fit, scanned downward so the lowest base is kept
	always_comb begin
		fit_found = 1'b0;
		fit_base  = '0;
		for (int b = NUM_PAIRS - 1; b >= 0; b--) begin
			if ((b + int'(alloc_pairs) <= NUM_PAIRS) &&
					((occupancy & pair_mask(PAIR_W'(b), alloc_pairs)) == '0)) begin
				fit_found = 1'b1;
				fit_base  = PAIR_W'(b);
			end
		end
	end

	// Low after a grant, and while fragmentation blocks the head request
	assign alloc_ready = !busy && fit_found;
	assign grant       = alloc_req && alloc_ready;
	assign grant_mask  = grant ? pair_mask(fit_base, alloc_pairs) : '0;
	assign rel_mask    = release_req ?
		pair_mask(warp_base[release_warp], warp_size[release_warp]) : '0;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			occupancy <= '0;
			busy      <= 1'b0;
		end else begin
			occupancy <= (occupancy & ~rel_mask) | grant_mask;
			busy      <= grant;
		end
	end

	// Per warp range and the base handed to the launch
	always_ff @(posedge clk) begin
		if (grant) begin
			warp_base[alloc_warp] <= fit_base;
			warp_size[alloc_warp] <= alloc_pairs;
			reg_base              <= {fit_base, 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== hw/task_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module task_manager import gpu_dispatch_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 push_task,
	input  logic [TASK_W-1:0]    task_word,
	input  logic                 start_cmd,
	input  logic                 clear_cmd,
	input  logic [TASK_W-1:0]    head_word,
	input  logic                 q_empty,
	input  logic [WARP_W-1:0]    free_warp,
	input  logic                 free_empty,
	input  logic [TASK_W-1:0]    exit_word,
	input  logic                 alloc_ready,
	input  logic                 exit_valid,
	input  logic [WARP_W-1:0]    exit_warp,
	output logic                 q_push,
	output logic                 q_pop,
	output logic                 q_invalidate,
	output logic                 q_reset,
	output logic                 wp_take,
	output logic                 wp_return,
	output logic                 wp_reset,
	output logic                 alloc_req,
	output logic [WARP_W-1:0]    alloc_warp,
	output logic [NREG_W-1:0]    alloc_pairs,
	output logic                 release_req,
	output logic [WARP_W-1:0]    release_warp,
	output logic                 launch_valid,
	output logic [WARP_W-1:0]    launch_warp,
	output logic [SW_ID_W-1:0]   launch_sw_id,
	output logic [MASK_W-1:0]    launch_mask,
	output logic [DATA_W-1:0]    launch_pc,
	output logic                 finished,
	output tm_state_e            state,
	output logic [ACT_W-1:0]     active_count
);

	logic                 head_ok;
	logic [REG_CNT_W-1:0] need_regs;
	logic [REG_CNT_W-1:0] free_regs;
	logic                 dispatch;
	logic                 exit_hit;

	// Head task present and still valid
	assign head_ok   = !q_empty && head_word[VALID_BIT];
	assign need_regs = task_regs(head_word);

	// All dispatch conditions in one cycle, exits take priority
	assign dispatch = (state == WORKING) && head_ok && !free_empty &&
		(need_regs <= free_regs) && alloc_ready && !exit_valid;
	// Warps only run while working
	assign exit_hit = exit_valid && (state == WORKING);

	// Only valid words are queued, and only before start
	assign q_push  = push_task && (state == WAITING) && task_word[VALID_BIT];
	assign q_pop   = dispatch;
	assign wp_take = dispatch;

	assign alloc_req   = dispatch;
	assign alloc_warp  = free_warp;
	// Idle request size keeps the allocator ready
	assign alloc_pairs = head_ok ? head_word[NREG_LSB +: NREG_W] : '0;

	// Exit bookkeeping
	assign q_invalidate = exit_hit;
	assign wp_return    = exit_hit;
	assign release_req  = exit_hit;
	assign release_warp = exit_warp;

	assign q_reset  = (state == CLEARING);
	assign wp_reset = (state == CLEARING);
	assign finished = (state == COMPLETE);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= WAITING;
		end else begin
			case (state)
				WAITING: begin
					// Clear beats start
					if (clear_cmd) begin
						state <= CLEARING;
					end else if (start_cmd) begin
						state <= WORKING;
					end
				end
				WORKING: begin
					// Nothing running and nothing left to launch
					if ((active_count == '0) && !head_ok) begin
						state <= COMPLETE;
					end
				end
				COMPLETE: begin
					if (clear_cmd) begin
						state <= CLEARING;
					end
				end
				default: begin
					state <= WAITING;
				end
			endcase
		end
	end

	// Register budget and running task count
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			free_regs    <= REG_CNT_W'(NUM_REGS);
			active_count <= '0;
		end else if (state == CLEARING) begin
			free_regs    <= REG_CNT_W'(NUM_REGS);
			active_count <= '0;
		end else if (dispatch) begin
			free_regs    <= free_regs - need_regs;
			active_count <= active_count + 1'b1;
		end else if (exit_hit) begin
			// Refund what the exiting task asked for
			free_regs    <= free_regs + task_regs(exit_word);
			active_count <= active_count - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			launch_valid <= 1'b0;
		end else begin
			launch_valid <= dispatch;
		end
	end

	// Launch fields captured with the decision
	always_ff @(posedge clk) begin
		if (dispatch) begin
			launch_warp  <= free_warp;
			launch_sw_id <= head_word[SW_ID_LSB +: SW_ID_W];
			launch_mask  <= head_word[MASK_LSB +: MASK_W];
			launch_pc    <= task_pc(head_word);
		end
	end

endmodule

`default_nettype wire

// ==== hw/dispatch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_regs import gpu_dispatch_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  reg_wen,
	input  logic [REG_ADDR_W-1:0] reg_addr,
	input  logic [DATA_W-1:0]     reg_wdata,
	input  logic                  finished,
	input  tm_state_e             state,
	input  logic [ACT_W-1:0]      active_count,
	output logic [DATA_W-1:0]     reg_rdata,
	output logic                  push_task,
	output logic [TASK_W-1:0]     task_word,
	output logic                  start_cmd,
	output logic                  clear_cmd
);

	logic              task_wr;
	logic              ctrl_wr;
	logic [DATA_W-1:0] status_word;

	assign task_wr = reg_wen && (reg_addr == ADDR_TASK);
	assign ctrl_wr = reg_wen && (reg_addr == ADDR_CTRL);

	// Bit 0 finished, bits 2:1 state, then the active count
	assign status_word = {{(DATA_W - ACT_W - 3){1'b0}}, active_count, state, finished};
	// Only the status register reads back
	assign reg_rdata = (reg_addr == ADDR_STATUS) ? status_word : '0;

	// One cycle command pulses
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			push_task <= 1'b0;
			start_cmd <= 1'b0;
			clear_cmd <= 1'b0;
		end else begin
			push_task <= task_wr;
			start_cmd <= ctrl_wr && reg_wdata[CTRL_START_BIT];
			clear_cmd <= ctrl_wr && reg_wdata[CTRL_CLEAR_BIT];
		end
	end

	// Word travels with its push pulse
	always_ff @(posedge clk) begin
		if (task_wr) begin
			task_word <= reg_wdata[TASK_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/gpu_dispatch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_dispatch_top import gpu_dispatch_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  reg_wen,
	input  logic [REG_ADDR_W-1:0] reg_addr,
	input  logic [DATA_W-1:0]     reg_wdata,
	output logic [DATA_W-1:0]     reg_rdata,
	input  logic                  exit_valid,
	input  logic [WARP_W-1:0]     exit_warp,
	output logic                  launch_valid,
	output logic [WARP_W-1:0]     launch_warp,
	output logic [SW_ID_W-1:0]    launch_sw_id,
	output logic [MASK_W-1:0]     launch_mask,
	output logic [DATA_W-1:0]     launch_pc,
	output logic [REG_BASE_W-1:0] reg_base,
	output logic                  finished
);

	// Host commands
	logic              push_task;
	logic [TASK_W-1:0] task_word;
	logic              start_cmd;
	logic              clear_cmd;
	tm_state_e         state;
	logic [ACT_W-1:0]  active_count;

	// Queue side
	logic               q_push;
	logic               q_pop;
	logic               q_invalidate;
	logic               q_reset;
	logic [TASK_W-1:0]  head_word;
	logic [TASK_AW-1:0] head_slot;
	logic               q_empty;
	logic [TASK_W-1:0]  exit_word;
	logic [TASK_AW-1:0] exit_slot;

	// Warp pool side
	logic              wp_take;
	logic              wp_return;
	logic              wp_reset;
	logic [WARP_W-1:0] free_warp;
	logic              free_empty;

	// Allocator side
	logic              alloc_req;
	logic [WARP_W-1:0] alloc_warp;
	logic [NREG_W-1:0] alloc_pairs;
	logic              alloc_ready;
	logic              release_req;
	logic [WARP_W-1:0] release_warp;

	dispatch_regs dispatch_regs_i (.*);

	task_manager task_manager_i (.*);

	task_queue task_queue_i (.*);

	warp_pool warp_pool_i (.*);

	reg_alloc_unit reg_alloc_unit_i (.*);

endmodule

`default_nettype wire

// ==== test/gpu_dispatch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_dispatch_checker (
	input logic clk,
	input logic rst,
	input logic launch_valid,
	input logic finished,
	input logic alloc_ready
);

	int unsigned failures = 0;

	// Gap of at least one cycle between launches
	single_launch: assert property (@(posedge clk) disable iff (!rst)
		launch_valid |=> !launch_valid)
	else begin
		$error("launch_valid high in two consecutive cycles");
		failures++;
	end

	// Done and launching are exclusive
	no_launch_when_done: assert property (@(posedge clk) disable iff (!rst)
		!(finished && launch_valid))
	else begin
		$error("finished and launch_valid high together");
		failures++;
	end

	// Allocator still busy while the launch it granted goes out
	busy_during_launch: assert property (@(posedge clk) disable iff (!rst)
		launch_valid |-> !alloc_ready)
	else begin
		$error("alloc_ready high while launch_valid is high");
		failures++;
	end

endmodule

bind gpu_dispatch_top gpu_dispatch_checker checker_i (
	.clk(clk),
	.rst(rst),
	.launch_valid(launch_valid),
	.finished(finished),
	.alloc_ready(alloc_ready)
);

`default_nettype wire

// ==== test/tb_gpu_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gpu_dispatch import gpu_dispatch_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int BATCH_MIN  = 12;
	localparam int BATCH_SPAN = 16;
	localparam int NUM_BATCHES = 2;
	// Longest time a warp stays active before its exit
	localparam int MAX_DELAY  = 12;
	// Generous bound per task, launches can serialize on registers
	localparam int CYCLES_PER_TASK = 4 * MAX_DELAY;
	localparam int WATCHDOG_CYCLES =
		NUM_BATCHES * (BATCH_MIN + BATCH_SPAN) * CYCLES_PER_TASK + 200;

	logic                  clk;
	logic                  rst;
	logic                  reg_wen;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [DATA_W-1:0]     reg_wdata;
	logic [DATA_W-1:0]     reg_rdata;
	logic                  exit_valid;
	logic [WARP_W-1:0]     exit_warp;
	logic                  launch_valid;
	logic [WARP_W-1:0]     launch_warp;
	logic [SW_ID_W-1:0]    launch_sw_id;
	logic [MASK_W-1:0]     launch_mask;
	logic [DATA_W-1:0]     launch_pc;
	logic [REG_BASE_W-1:0] reg_base;
	logic                  finished;

	// Reference model state
	logic [31:0]       seed = 32'd77336;
	logic [TASK_W-1:0] expected_q [$];
	logic [WARP_W-1:0] free_q [$];
	bit                active [NUM_WARPS];
	bit                used_warp [NUM_WARPS];
	int                base_of [NUM_WARPS];
	int                size_of [NUM_WARPS];
	int                delay_of [NUM_WARPS];
	int                free_regs;
	int                valid_pushes;
	int                launches;
	bit                reused;

	gpu_dispatch_top gpu_dispatch_top_i (
		.clk(clk), .rst(rst),
		.reg_wen(reg_wen), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.exit_valid(exit_valid), .exit_warp(exit_warp),
		.launch_valid(launch_valid), .launch_warp(launch_warp), .launch_sw_id(launch_sw_id),
		.launch_mask(launch_mask), .launch_pc(launch_pc), .reg_base(reg_base),
		.finished(finished)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Hang guard sized from the task counts
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: dispatch did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

	// Stop at the first assertion failure of the bound checker
	initial begin
		wait (gpu_dispatch_top_i.checker_i.failures != 0);
		$display("bound checker reported an assertion failure");
		$display("FAIL: see errors above");
		$fatal(1, "assertion failure");
	end

	// LCG, full 32 bit state
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int random_below(input int n);
		return int'((next_random() >> 8) % n);
	endfunction

	// Warps the model has running
	function automatic int count_active();
		int n;
		n = 0;
		for (int i = 0; i < NUM_WARPS; i++) begin
			n += int'(active[i]);
		end
		return n;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "check failed");
		end
	endtask

	// Fresh model, same as DUT after reset or clear
	task automatic reset_model();
		expected_q.delete();
		free_q.delete();
		for (int i = 0; i < NUM_WARPS; i++) begin
			free_q.push_back(WARP_W'(i));
			active[i]    = 1'b0;
			used_warp[i] = 1'b0;
		end
		free_regs    = NUM_REGS;
		valid_pushes = 0;
		launches     = 0;
		reused       = 1'b0;
	endtask

	// One cycle host write, address parked on status afterwards
	task automatic host_write(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		reg_wen   = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_wen   = 1'b0;
		reg_addr  = ADDR_STATUS;
		reg_wdata = '0;
	endtask

	task automatic push_batch(input int count);
		logic [TASK_W-1:0] word;
		for (int i = 0; i < count; i++) begin
			word = TASK_W'(next_random());
			// Roughly one in five words is invalid, the first never
			word[VALID_BIT] = (i == 0) || (random_below(5) != 0);
			if (word[VALID_BIT]) begin
				expected_q.push_back(word);
				valid_pushes++;
			end
			host_write(ADDR_TASK, DATA_W'(word));
		end
	endtask

	// Compare a launch against the head of the model
	task automatic take_launch();
		logic [TASK_W-1:0] word;
		logic [WARP_W-1:0] warp;
		int                need;
		int                base;
		check_equal("launch with a task pending", 1, expected_q.size() != 0);
		word = expected_q.pop_front();
		warp = free_q.pop_front();
		need = 2 * int'(word[NREG_LSB +: NREG_W]);
		base = int'(reg_base);
		check_equal("launch sw id", word[SW_ID_LSB +: SW_ID_W], launch_sw_id);
		check_equal("launch mask", word[MASK_LSB +: MASK_W], launch_mask);
		check_equal("launch pc", DATA_W'(word[PC_LSB +: PC_W]) * 4, launch_pc);
		check_equal("launch warp order", warp, launch_warp);
		check_equal("launch warp idle", 0, active[launch_warp]);
		check_equal("register budget", 1, need <= free_regs);
		check_equal("register range bound", 1, base + need <= NUM_REGS);
		for (int w = 0; w < NUM_WARPS; w++) begin
			if (active[w] && need > 0 && size_of[w] > 0) begin
				check_equal("register range overlap", 0,
					(base < base_of[w] + size_of[w]) && (base_of[w] < base + need));
			end
		end
		if (used_warp[launch_warp]) begin
			reused = 1'b1;
		end
		used_warp[launch_warp] = 1'b1;
		active[launch_warp]    = 1'b1;
		base_of[launch_warp]   = base;
		size_of[launch_warp]   = need;
		delay_of[launch_warp]  = 1 + random_below(MAX_DELAY);
		free_regs -= need;
		launches++;
	endtask

	// Issue unit stand-in, at most one exit per cycle
	task automatic drive_exit();
		int start;
		int w;
		exit_valid = 1'b0;
		for (int i = 0; i < NUM_WARPS; i++) begin
			if (active[i] && delay_of[i] > 0) begin
				delay_of[i]--;
			end
		end
		start = random_below(NUM_WARPS);
		for (int i = 0; i < NUM_WARPS; i++) begin
			w = (start + i) % NUM_WARPS;
			if (!exit_valid && active[w] && delay_of[w] == 0) begin
				exit_valid = 1'b1;
				exit_warp  = WARP_W'(w);
				active[w]  = 1'b0;
				free_regs += size_of[w];
				free_q.push_back(WARP_W'(w));
			end
		end
	endtask

	task automatic run_batch(input int count);
		push_batch(count);
		host_write(ADDR_CTRL, DATA_W'(1) << CTRL_START_BIT);
		// Start pulse is registered, WORKING shows one cycle later
		@(negedge clk);
		// Sample on the falling edge, then drive this cycle's exit
		while (finished !== 1'b1) begin
			if (launch_valid) begin
				take_launch();
			end
			check_equal("status while working",
				(DATA_W'(count_active()) << 3) | (DATA_W'(WORKING) << 1), reg_rdata);
			drive_exit();
			@(negedge clk);
		end
		exit_valid = 1'b0;
		check_equal("launch count", valid_pushes, launches);
		check_equal("tasks left at finish", 0, expected_q.size());
		check_equal("warps returned at finish", NUM_WARPS, free_q.size());
		check_equal("registers returned at finish", NUM_REGS, free_regs);
		check_equal("status at finish", (DATA_W'(COMPLETE) << 1) | 1, reg_rdata);
		if (valid_pushes > NUM_WARPS) begin
			check_equal("warp id reused", 1, reused);
		end
	endtask

	initial begin
		rst        = 1'b0;
		reg_wen    = 1'b0;
		reg_addr   = ADDR_STATUS;
		reg_wdata  = '0;
		exit_valid = 1'b0;
		exit_warp  = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_equal("status after reset", 0, reg_rdata);
		check_equal("launch_valid after reset", 0, launch_valid);
		reset_model();
		run_batch(BATCH_MIN + random_below(BATCH_SPAN));
		// Register stage, then one CLEARING cycle
		host_write(ADDR_CTRL, DATA_W'(1) << CTRL_CLEAR_BIT);
		repeat (2) @(negedge clk);
		check_equal("status after clear", 0, reg_rdata);
		check_equal("finished after clear", 0, finished);
		check_equal("launch_valid after clear", 0, launch_valid);
		reset_model();
		run_batch(BATCH_MIN + random_below(BATCH_SPAN));
		if (gpu_dispatch_top_i.checker_i.failures == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("bound checker saw %0d assertion failures",
				gpu_dispatch_top_i.checker_i.failures);
			$display("FAIL: see errors above");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
hw/gpu_dispatch_pkg.sv
hw/task_queue.sv
hw/warp_pool.sv
hw/reg_alloc_unit.sv
hw/task_manager.sv
hw/dispatch_regs.sv
hw/gpu_dispatch_top.sv
test/gpu_dispatch_checker.sv
test/tb_gpu_dispatch.sv

// ==== Bender.yml ====
package:
  name: gpu_dispatch

sources:
  - hw/gpu_dispatch_pkg.sv
  - hw/task_queue.sv
  - hw/warp_pool.sv
  - hw/reg_alloc_unit.sv
  - hw/task_manager.sv
  - hw/dispatch_regs.sv
  - hw/gpu_dispatch_top.sv
  - target: test
    files:
      - test/gpu_dispatch_checker.sv
      - test/tb_gpu_dispatch.sv
